// File: common/trace_pkg.sv
package trace_pkg;

	localparam int NUM_WORDS = 6;        // Status words per step
	localparam int RECORDS_PER_STEP = 7; // Six words plus line end
	localparam int FIFO_RECORDS = 8;
	localparam int BYTES_PER_RECORD = 8;
	localparam int BAUD_DIV = 8;         // Clocks per serial bit
	localparam int GAP_CYCLES = 16;      // Pause before each byte

	localparam int FIFO_AW = $clog2(FIFO_RECORDS);
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
	localparam int GAP_CNT_W = $clog2(GAP_CYCLES);

	// Slot that carries the line end instead of a word
	localparam logic [2:0] LINE_SLOT = 3'(NUM_WORDS);
	localparam logic [2:0] LAST_SLOT = 3'(RECORDS_PER_STEP - 1);
	localparam logic [3:0] LAST_BYTE = 4'(BYTES_PER_RECORD - 1);
	localparam logic [BAUD_CNT_W-1:0] LAST_BAUD = BAUD_CNT_W'(BAUD_DIV - 1);
	localparam logic [GAP_CNT_W-1:0] LAST_GAP = GAP_CNT_W'(GAP_CYCLES - 1);

	typedef struct packed {
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		logic [31:0] w4;
		logic [31:0] w5;
		logic [31:0] w6;
	} trace_words_t;

	// c7 leaves the FIFO first
	typedef struct packed {
		logic [7:0] c7;
		logic [7:0] c6;
		logic [7:0] c5;
		logic [7:0] c4;
		logic [7:0] c3;
		logic [7:0] c2;
		logic [7:0] c1;
		logic [7:0] c0;
	} trace_record_t;

	// Upper case hex digit
	function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h37 + {4'h0, nib}; // 'A' is 8'h41
	endfunction

	localparam trace_record_t line_end_record = '{
		c7: 8'h20, c6: 8'h20, c5: 8'h20, c4: 8'h20,
		c3: 8'h20, c2: 8'h20,
		c1: 8'h0d, // CR
		c0: 8'h0a  // LF
	};

endpackage

// File: trace/trace_ctrl.sv
`timescale 1ns/1ps

module trace_ctrl (
	input  logic       clk,
	input  logic       rst,
	input  logic       cpu_halted,
	input  logic       fifo_empty,
	input  logic       fifo_full,
	input  logic       tx_idle,
	output logic       halt_cpu,
	output logic       step,
	output logic       wr_en,
	output logic [2:0] slot,
	output logic       rd_en,
	output logic       trmt
);

	typedef enum logic [2:0] {
		IDLE,
		STEP,  // CPU runs this cycle
		SNAP,  // Formatter captures the words
		WRITE, // One record per slot
		GAP,
		READ,
		SEND
	} state_t;

	state_t state;
	state_t next_state;
	logic [2:0] slot_q;
	logic [trace_pkg::GAP_CNT_W-1:0] gap_cnt;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Slot counter runs only while writing
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			slot_q <= '0;
		else if (state == WRITE)
			slot_q <= slot_q + 3'd1;
		else
			slot_q <= '0;
	end

	// The IDLE cycle that starts a drain counts as the first gap cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			gap_cnt <= '0;
		else if (next_state == GAP)
			gap_cnt <= gap_cnt + 1'b1;
		else
			gap_cnt <= '0;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (fifo_empty && tx_idle && !cpu_halted)
					next_state = STEP;
				else if (!fifo_empty && tx_idle)
					next_state = GAP; // Drain even while halted
			end
			STEP:  next_state = SNAP;
			SNAP:  next_state = WRITE;
			WRITE: begin
				if (slot_q == trace_pkg::LAST_SLOT)
					next_state = IDLE;
			end
			GAP: begin
				if (gap_cnt == trace_pkg::LAST_GAP)
					next_state = READ;
			end
			READ:  next_state = SEND;
			SEND:  next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// Outputs decoded from state
	assign halt_cpu = (state != STEP);
	assign step = (state == STEP);
	assign wr_en = (state == WRITE);
	assign slot = slot_q;
	assign rd_en = (state == READ);
	assign trmt = (state == SEND);

	// A step starts on an empty FIFO and writes fewer records than it holds
	wr_not_full: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> !fifo_full);

	rd_not_empty: assert property (@(posedge clk) disable iff (rst)
		rd_en |-> !fifo_empty);

	// Single cycle of CPU execution per step
	one_cycle_step: assert property (@(posedge clk) disable iff (rst)
		!halt_cpu |=> halt_cpu);

endmodule

// File: trace/trace_formatter.sv
`timescale 1ns/1ps

module trace_formatter (
	input  logic                     clk,
	input  logic                     rst,
	input  trace_pkg::trace_words_t  words,
	input  logic                     step,
	input  logic [2:0]               slot,
	output trace_pkg::trace_record_t record
);

	logic step_q;
	trace_pkg::trace_words_t snap;
	logic [31:0] word;
	logic [63:0] hex_bits;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			step_q <= 1'b0;
		else
			step_q <= step;
	end

	// Words after the step, held while the text drains
	always_ff @(posedge clk) begin
		if (step_q)
			snap <= words;
	end

	always_comb begin
		case (slot)
			3'd0: word = snap.w1;
			3'd1: word = snap.w2;
			3'd2: word = snap.w3;
			3'd3: word = snap.w4;
			3'd4: word = snap.w5;
			3'd5: word = snap.w6;
			default: word = '0;
		endcase
	end

	// Top nibble lands in c7
	always_comb begin
		for (int i = 0; i < 8; i++)
			hex_bits[8*i +: 8] = trace_pkg::hex_ascii(word[4*i +: 4]);
	end

	always_comb begin
		if (slot == trace_pkg::LINE_SLOT)
			record = trace_pkg::line_end_record;
		else
			record = trace_pkg::trace_record_t'(hex_bits);
	end

endmodule

// File: source/trace_fifo.sv
`timescale 1ns/1ps

module trace_fifo (
	input  logic                     clk,
	input  logic                     rst,
	input  trace_pkg::trace_record_t din,
	input  logic                     wr_en,
	input  logic                     rd_en,
	output logic [7:0]               dout,
	output logic                     empty,
	output logic                     full
);

	localparam int AW = trace_pkg::FIFO_AW;

	trace_pkg::trace_record_t mem [trace_pkg::FIFO_RECORDS];
	trace_pkg::trace_record_t head;
	logic [AW:0] wr_ptr; // Extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic [3:0]  byte_idx;
	logic [7:0]  head_byte;

	always_ff @(posedge clk) begin
		if (wr_en && !full)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			wr_ptr <= '0;
		else if (wr_en && !full)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// Record leaves after its eighth byte
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			byte_idx <= '0;
		end else if (rd_en && !empty) begin
			if (byte_idx == trace_pkg::LAST_BYTE) begin
				byte_idx <= '0;
				rd_ptr <= rd_ptr + 1'b1;
			end else begin
				byte_idx <= byte_idx + 4'd1;
			end
		end
	end

	assign head = mem[rd_ptr[AW-1:0]];

	always_comb begin
		case (byte_idx[2:0])
			3'd0: head_byte = head.c7;
			3'd1: head_byte = head.c6;
			3'd2: head_byte = head.c5;
			3'd3: head_byte = head.c4;
			3'd4: head_byte = head.c3;
			3'd5: head_byte = head.c2;
			3'd6: head_byte = head.c1;
			default: head_byte = head.c0;
		endcase
	end

	// Popped byte stays on dout for the transmitter load
	always_ff @(posedge clk) begin
		if (rd_en && !empty)
			dout <= head_byte;
	end

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	byte_idx_range: assert property (@(posedge clk) disable iff (rst)
		byte_idx <= trace_pkg::LAST_BYTE);

endmodule

// File: source/serial_tx.sv
`timescale 1ns/1ps

module serial_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       trmt,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_idle
);

	logic [9:0] shift;   // Stop, data, start
	logic [3:0] bit_cnt; // Bits sent in this frame
	logic [trace_pkg::BAUD_CNT_W-1:0] baud_cnt;
	logic baud_done;

	assign baud_done = (baud_cnt == trace_pkg::LAST_BAUD);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			baud_cnt <= '0;
		else if (tx_idle || baud_done)
			baud_cnt <= '0;
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

	// Line rests at 1, so shift in ones behind the frame
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			shift <= '1;
		else if (tx_idle && trmt)
			shift <= {1'b1, tx_data, 1'b0};
		else if (!tx_idle && baud_done)
			shift <= {1'b1, shift[9:1]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			bit_cnt <= '0;
		else if (tx_idle)
			bit_cnt <= '0;
		else if (baud_done)
			bit_cnt <= bit_cnt + 4'd1;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			tx_idle <= 1'b1;
		else if (tx_idle && trmt)
			tx_idle <= 1'b0;
		else if (baud_done && bit_cnt == 4'd9)
			tx_idle <= 1'b1; // End of stop bit
	end

	assign tx = shift[0];

	// Nothing but the stop level on the line between frames
	idle_line_high: assert property (@(posedge clk) disable iff (rst)
		tx_idle |-> tx);

endmodule

// File: source/cpu_trace.sv
`timescale 1ns/1ps

module cpu_trace (
	input  logic                    clk,
	input  logic                    rst,
	input  trace_pkg::trace_words_t words,
	input  logic                    cpu_halted,
	output logic                    tx,
	output logic                    halt_cpu
);

	logic step;
	logic wr_en;
	logic [2:0] slot;
	logic rd_en;
	logic trmt;
	logic fifo_empty;
	logic fifo_full;
	logic tx_idle;
	logic [7:0] tx_data;
	trace_pkg::trace_record_t record;

	trace_ctrl ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.cpu_halted (cpu_halted),
		.fifo_empty (fifo_empty),
		.fifo_full  (fifo_full),
		.tx_idle    (tx_idle),
		.halt_cpu   (halt_cpu),
		.step       (step),
		.wr_en      (wr_en),
		.slot       (slot),
		.rd_en      (rd_en),
		.trmt       (trmt)
	);

	trace_formatter formatter_i (
		.clk    (clk),
		.rst    (rst),
		.words  (words),
		.step   (step),
		.slot   (slot),
		.record (record)
	);

	trace_fifo fifo_i (
		.clk   (clk),
		.rst   (rst),
		.din   (record),
		.wr_en (wr_en),
		.rd_en (rd_en),
		.dout  (tx_data),
		.empty (fifo_empty),
		.full  (fifo_full)
	);

	serial_tx tx_i (
		.clk     (clk),
		.rst     (rst),
		.trmt    (trmt),
		.tx_data (tx_data),
		.tx      (tx),
		.tx_idle (tx_idle)
	);

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	localparam realtime HALF_PERIOD = 10ns; // 20 ns period

	initial begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: sim/cpu_trace_tb.sv
`timescale 1ns/1ps

module cpu_trace_tb;

	localparam int BYTES_PER_STEP = 56;
	localparam int MIN_FRAME_GAP = 10 * trace_pkg::BAUD_DIV + trace_pkg::GAP_CYCLES;
	localparam int STEP_DRAIN = BYTES_PER_STEP * (MIN_FRAME_GAP + 2); // Cycles to send one step

	logic clk;
	logic rst;
	trace_pkg::trace_words_t words;
	logic cpu_halted;
	logic tx;
	logic halt_cpu;

	trace_pkg::trace_words_t case_words[$];
	int case_halt[$];
	int case_hold[$];
	int num_cases;
	int seed;
	int errors;
	int cycles;
	int limit;
	int steps;            // Step pulses seen so far
	int rx_bytes;
	int step_first_error;
	int halted_bytes;     // Bytes received with cpu_halted high
	int hold_left;
	logic apply_pending;
	logic scramble_pending;
	logic done;

	tb_clock clock_i (.clk(clk));

	cpu_trace cpu_trace_i (
		.clk        (clk),
		.rst        (rst),
		.words      (words),
		.cpu_halted (cpu_halted),
		.tx         (tx),
		.halt_cpu   (halt_cpu)
	);

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("failure at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		string digits;
		digits = "0123456789ABCDEF";
		return digits.getc(int'(nib));
	endfunction

	// Text of one step: six words as hex, then six spaces, CR, LF
	function automatic logic [7:0] expected_byte(input trace_pkg::trace_words_t w, input int pos);
		logic [191:0] flat;
		logic [31:0] word;
		flat = w;
		if (pos < 48) begin
			word = flat[191 - 32 * (pos / 8) -: 32];
			return hex_char(word[4 * (7 - pos % 8) +: 4]);
		end
		if (pos < 54)
			return 8'h20;
		if (pos == 54)
			return 8'h0d;
		return 8'h0a;
	endfunction

	task automatic load_cases();
		int fd;
		int code;
		int halt;
		int hold;
		string line;
		logic [31:0] w [6];
		trace_pkg::trace_words_t cw;
		fd = $fopen("sim/trace_cases.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0) begin
				code = $sscanf(line, "%d %h %h %h %h %h %h %d",
					halt, w[0], w[1], w[2], w[3], w[4], w[5], hold);
				if (code == 8) begin // Comment lines do not match
					cw = {w[0], w[1], w[2], w[3], w[4], w[5]};
					case_words.push_back(cw);
					case_halt.push_back(halt);
					case_hold.push_back(hold);
				end
			end
		end
		$fclose(fd);
		num_cases = case_words.size();
	endtask

	task automatic take_byte(input logic [7:0] data);
		int idx;
		int pos;
		idx = rx_bytes / BYTES_PER_STEP;
		pos = rx_bytes % BYTES_PER_STEP;
		if (idx >= num_cases)
			note_failure("byte received after the last case");
		else
			check_equal({24'b0, data}, {24'b0, expected_byte(case_words[idx], pos)},
				$sformatf("step %0d byte %0d", idx + 1, pos));
		if (cpu_halted)
			halted_bytes++;
		rx_bytes++;
		if (pos == BYTES_PER_STEP - 1) begin
			// A halt longer than the whole drain must not hold back queued bytes
			if (idx < num_cases && case_halt[idx] != 0 &&
					case_hold[idx] > STEP_DRAIN + trace_pkg::GAP_CYCLES)
				check_equal(halted_bytes, BYTES_PER_STEP,
					$sformatf("step %0d bytes sent while halted", idx + 1));
			$display("step %0d: %0d bytes, %0d sent while halted, %0d errors",
				idx + 1, BYTES_PER_STEP, halted_bytes, errors - step_first_error);
			step_first_error = errors;
			halted_bytes = 0;
			if (idx + 1 == num_cases)
				done = 1'b1;
		end
	endtask

	always @(posedge clk) cycles <= cycles + 1;

	always @(negedge clk) begin
		if (cycles >= limit) begin
			$display("timeout: run stopped after %0d cycles with %0d of %0d steps received",
				cycles, rx_bytes / BYTES_PER_STEP, num_cases);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// CPU model, one instruction per step pulse
	always @(negedge clk) begin : cpu_model
		logic new_step;
		int idx;
		new_step = 1'b0;
		if (rst) begin
			check_equal({31'b0, halt_cpu}, 32'd1, "halt_cpu in reset");
			check_equal({31'b0, tx}, 32'd1, "tx in reset");
		end else begin
			if (!halt_cpu) begin
				new_step = 1'b1;
				if (cpu_halted)
					note_failure($sformatf("step %0d started while the CPU was halted", steps + 1));
				if (rx_bytes != steps * BYTES_PER_STEP)
					note_failure($sformatf("step %0d started with only %0d bytes received",
						steps + 1, rx_bytes));
				steps++;
			end
			if (cpu_halted) begin
				if (hold_left <= 1)
					cpu_halted <= 1'b0;
				else
					hold_left--;
			end
			if (apply_pending) begin
				idx = steps - 1;
				if (idx < num_cases) begin
					words = case_words[idx];
					if (case_halt[idx] != 0) begin
						cpu_halted <= 1'b1;
						hold_left = case_hold[idx] + ($random(seed) & 3);
					end
				end
				scramble_pending = 1'b1;
			end else if (scramble_pending) begin
				// Snapshot already taken, so this must not reach the text
				scramble_pending = 1'b0;
				words = {$random(seed), $random(seed), $random(seed),
					$random(seed), $random(seed), $random(seed)};
			end
			apply_pending = new_step;
			if (steps == 0)
				check_equal({31'b0, tx}, 32'd1, "tx before the first step");
		end
	end

	// Serial receiver, samples near the middle of each bit
	initial begin : receiver
		logic line_prev;
		logic [7:0] data;
		int last_start;
		last_start = -1;
		@(negedge clk);
		forever begin
			line_prev = tx;
			@(negedge clk);
			if (line_prev === 1'b1 && tx === 1'b0) begin
				if (steps == 0)
					note_failure("start bit seen before the first step");
				if (last_start >= 0 && cycles - last_start < MIN_FRAME_GAP)
					note_failure($sformatf("start bits only %0d cycles apart",
						cycles - last_start));
				last_start = cycles;
				repeat (trace_pkg::BAUD_DIV / 2 - 1) @(negedge clk);
				check_equal({31'b0, tx}, 32'd0, "start bit");
				for (int i = 0; i < 8; i++) begin
					repeat (trace_pkg::BAUD_DIV) @(negedge clk);
					data[i] = tx; // LSB first
				end
				repeat (trace_pkg::BAUD_DIV) @(negedge clk);
				check_equal({31'b0, tx}, 32'd1, "stop bit");
				take_byte(data);
			end
		end
	end

	initial begin
		rst = 1'b1;
		cpu_halted <= 1'b1; // Short halt right after reset
		words = '0;
		seed = 23;
		errors = 0;
		cycles = 0;
		steps = 0;
		rx_bytes = 0;
		step_first_error = 0;
		halted_bytes = 0;
		hold_left = 20;
		apply_pending = 1'b0;
		scramble_pending = 1'b0;
		done = 1'b0;
		num_cases = 0;
		limit = 1000;
		load_cases();
		limit = num_cases * 6000 + 1000;
		if (num_cases == 0) begin
			$display("no test cases could be read from sim/trace_cases.txt");
			$display("Simulation FAILED");
			$finish;
		end else begin
			repeat (10) @(negedge clk);
			rst = 1'b0;
			wait (done);
			$display("%0d steps, %0d bytes, %0d errors", steps, rx_bytes, errors);
			if (errors == 0)
				$display("Simulation PASSED");
			else
				$display("Simulation FAILED");
			$finish;
		end
	end

endmodule

// File: sim/trace_cases.txt
# halt w1 w2 w3 w4 w5 w6 hold
# halt is 0 or 1, words are hex, hold is the halt length in cycles
0 00000000 12345678 9ABCDEF0 FFFFFFFF 0000FFFF DEADBEEF 0
1 CAFEF00D 00000001 80000000 A5A5A5A5 5A5A5A5A 0F0F0F0F 40
0 FEDCBA98 76543210 01234567 89ABCDEF 13579BDF 2468ACE0 0
1 11111111 22222222 33333333 44444444 55555555 66666666 5800
0 AAAAAAAA BBBBBBBB CCCCCCCC DDDDDDDD EEEEEEEE 7FFFFFFF 0
1 00C0FFEE 10203040 F00DFACE 0BADC0DE 31415926 27182818 300

// File: build.f
common/trace_pkg.sv
trace/trace_ctrl.sv
trace/trace_formatter.sv
source/trace_fifo.sv
source/serial_tx.sv
source/cpu_trace.sv
sim/tb_clock.sv
sim/cpu_trace_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cpu_trace_tb -o cpu_trace_sim

output=$(./obj_dir/cpu_trace_sim 2>&1)
echo "$output"

echo "$output" | grep -qx "Simulation PASSED"
